// File: hdl/chip8_bus_pkg.sv
// memory port widths and program layout
// shared by every block that carries addresses or bytes
`default_nettype none

package chip8_bus_pkg;

  typedef logic [11:0] addr_t;
  typedef logic [7:0] data_t;

  // programs are loaded here and pc starts here
  localparam addr_t PROGRAM_START = 12'h200;
  localparam addr_t INSTR_BYTES = 12'd2;

endpackage

`default_nettype wire

// File: hdl/chip8_isa_pkg.sv
// CHIP-8 instruction word layout and opcode classes
// used by the control unit for decode and by the register file for the flag index
`default_nettype none

package chip8_isa_pkg;

  typedef logic [3:0] reg_idx_t;

  typedef struct packed {
    logic [3:0] op;
    reg_idx_t x;
    reg_idx_t y;
    logic [3:0] n;
  } nib_view_t;

  typedef struct packed {
    logic [3:0] op;
    reg_idx_t x;
    logic [7:0] kk;
  } imm_view_t;

  typedef struct packed {
    logic [3:0] op;
    logic [11:0] nnn;
  } addr_view_t;

  // one fetched word, read through whichever view the class needs
  typedef union packed {
    nib_view_t nib;
    imm_view_t imm;
    addr_view_t addr;
  } opcode_t;

  // top nibble classes
  localparam logic [3:0] OP_SYS = 4'h0;
  localparam logic [3:0] OP_JP = 4'h1;
  localparam logic [3:0] OP_CALL = 4'h2;
  localparam logic [3:0] OP_SE_IMM = 4'h3;
  localparam logic [3:0] OP_SNE_IMM = 4'h4;
  localparam logic [3:0] OP_SE_REG = 4'h5;
  localparam logic [3:0] OP_LD_IMM = 4'h6;
  localparam logic [3:0] OP_ADD_IMM = 4'h7;
  localparam logic [3:0] OP_ALU = 4'h8;
  localparam logic [3:0] OP_SNE_REG = 4'h9;
  localparam logic [3:0] OP_LD_I = 4'hA;
  localparam logic [3:0] OP_JP_V0 = 4'hB;
  localparam logic [3:0] OP_MISC = 4'hF;

  // low byte of the Fxkk group
  localparam logic [7:0] MISC_GET_DT = 8'h07;
  localparam logic [7:0] MISC_SET_DT = 8'h15;
  localparam logic [7:0] MISC_ADD_I = 8'h1E;
  localparam logic [7:0] MISC_BCD = 8'h33;
  localparam logic [7:0] MISC_STORE = 8'h55;
  localparam logic [7:0] MISC_LOAD = 8'h65;

  localparam logic [15:0] OPC_RET = 16'h00EE;
  localparam reg_idx_t FLAG_REG = 4'hF;

endpackage

`default_nettype wire

// File: hdl/chip8_alu.sv
// 8xyN arithmetic and logic with VF flag generation
`timescale 1ns/1ns
`default_nettype none

module chip8_alu (
  input wire chip8_bus_pkg::data_t a,
  input wire chip8_bus_pkg::data_t b,
  input wire [3:0] n,
  output chip8_bus_pkg::data_t result,
  output logic flag,
  output logic flag_en
);

  logic [8:0] sum;

  assign sum = {1'b0, a} + {1'b0, b};

  always_comb begin
    result = a;
    flag = 1'b0;
    flag_en = 1'b1;
    case (n)
      4'h0: begin
        result = b;
        flag_en = 1'b0;
      end
      4'h1: begin
        result = a | b;
        flag_en = 1'b0;
      end
      4'h2: begin
        result = a & b;
        flag_en = 1'b0;
      end
      4'h3: begin
        result = a ^ b;
        flag_en = 1'b0;
      end
      4'h4: begin
        result = sum[7:0];
        flag = sum[8];
      end
      // flag is the no-borrow bit
      4'h5: begin
        result = a - b;
        flag = (a >= b);
      end
      4'h6: begin
        result = a >> 1;
        flag = a[0];
      end
      4'h7: begin
        result = b - a;
        flag = (b > a);
      end
      4'hE: begin
        result = a << 1;
        flag = a[7];
      end
      default: flag_en = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/chip8_regfile.sv
// V0..VF register file, two combinational reads and a result write plus a flag write
`timescale 1ns/1ns
`default_nettype none

module chip8_regfile (
  input wire clk,
  input wire reset,
  input wire chip8_isa_pkg::reg_idx_t rd_x_idx,
  input wire chip8_isa_pkg::reg_idx_t rd_y_idx,
  input wire wr_en,
  input wire chip8_isa_pkg::reg_idx_t wr_idx,
  input wire chip8_bus_pkg::data_t wr_data,
  input wire flag_wr_en,
  input wire chip8_bus_pkg::data_t flag_data,
  output chip8_bus_pkg::data_t rd_x_data,
  output chip8_bus_pkg::data_t rd_y_data
);

  chip8_bus_pkg::data_t regs [16];

  assign rd_x_data = regs[rd_x_idx];
  assign rd_y_data = regs[rd_y_idx];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int r = 0; r < 16; r++) begin
        regs[r] <= '0;
      end
    end else begin
      if (wr_en) regs[wr_idx] <= wr_data;
      // later assignment, so VF keeps the flag when x is 15
      if (flag_wr_en) regs[chip8_isa_pkg::FLAG_REG] <= flag_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/chip8_call_stack.sv
// return address LIFO for 2nnn and 00EE, top shows the last pushed entry
`timescale 1ns/1ns
`default_nettype none

module chip8_call_stack #(
  parameter int STACK_DEPTH = 16
) (
  input wire clk,
  input wire reset,
  input wire push,
  input wire pop,
  input wire chip8_bus_pkg::addr_t push_addr,
  output chip8_bus_pkg::addr_t top
);

  localparam int IDX_W = $clog2(STACK_DEPTH);
  localparam logic [IDX_W:0] FULL_COUNT = (IDX_W + 1)'(STACK_DEPTH);

  chip8_bus_pkg::addr_t entries [STACK_DEPTH];
  logic [IDX_W:0] count;
  logic [IDX_W-1:0] top_idx;

  assign top_idx = count[IDX_W-1:0] - IDX_W'(1);
  assign top = entries[top_idx];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (push) begin
      count <= count + 1'b1;
    end else if (pop) begin
      count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) entries[count[IDX_W-1:0]] <= push_addr;
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> count != FULL_COUNT);
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> count != '0);

endmodule

`default_nettype wire

// File: hdl/chip8_delay_timer.sv
// delay timer, counts down once per TICK_DIV clocks while nonzero
`timescale 1ns/1ns
`default_nettype none

module chip8_delay_timer #(
  parameter int TICK_DIV = 1666667
) (
  input wire clk,
  input wire reset,
  input wire load,
  input wire chip8_bus_pkg::data_t load_value,
  output chip8_bus_pkg::data_t value
);

  localparam int CNT_W = $clog2(TICK_DIV + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(TICK_DIV - 1);

  logic [CNT_W-1:0] div_cnt;
  logic tick;

  assign tick = (div_cnt == LAST);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
      value <= '0;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      // a load in the same cycle as a tick wins
      if (load) begin
        value <= load_value;
      end else if (tick && value != '0) begin
        value <= value - 8'd1;
      end
    end
  end

  a_div_valid: assert property (@(posedge clk) TICK_DIV >= 1);

endmodule

`default_nettype wire

// File: hdl/chip8_control.sv
// fetch/execute sequencer, owns pc, I and the instruction register
// and drives every memory request, including BCD and block moves
`timescale 1ns/1ns
`default_nettype none

module chip8_control (
  input wire clk,
  input wire reset,
  input wire mem_req_ready,
  input wire mem_rsp_valid,
  input wire chip8_bus_pkg::data_t mem_rdata,
  input wire chip8_bus_pkg::data_t rd_x_data,
  input wire chip8_bus_pkg::data_t rd_y_data,
  input wire chip8_bus_pkg::data_t alu_result,
  input wire alu_flag,
  input wire alu_flag_en,
  input wire chip8_bus_pkg::addr_t stack_top,
  input wire chip8_bus_pkg::data_t timer_value,
  output logic mem_req_valid,
  output logic mem_req_write,
  output chip8_bus_pkg::addr_t mem_addr,
  output chip8_bus_pkg::data_t mem_wdata,
  output chip8_isa_pkg::reg_idx_t rd_x_idx,
  output chip8_isa_pkg::reg_idx_t rd_y_idx,
  output logic wr_en,
  output chip8_isa_pkg::reg_idx_t wr_idx,
  output chip8_bus_pkg::data_t wr_data,
  output logic flag_wr_en,
  output chip8_bus_pkg::data_t flag_data,
  output logic [3:0] alu_n,
  output logic stack_push,
  output logic stack_pop,
  output chip8_bus_pkg::addr_t push_addr,
  output logic timer_load,
  output chip8_bus_pkg::data_t timer_load_value
);

  typedef enum logic [3:0] {
    S_FETCH_HI, S_FETCH_HI_WAIT, S_FETCH_LO, S_FETCH_LO_WAIT,
    S_EXEC, S_BCD, S_STORE, S_LOAD, S_LOAD_WAIT
  } state_t;

  state_t state;
  chip8_bus_pkg::addr_t pc;
  chip8_bus_pkg::addr_t i_reg;
  chip8_isa_pkg::opcode_t ir;
  chip8_isa_pkg::reg_idx_t cnt;
  chip8_bus_pkg::addr_t blk_addr;
  chip8_bus_pkg::data_t bcd_digit;
  logic skip;
  logic is_ret;

  assign is_ret = (ir == chip8_isa_pkg::OPC_RET);
  assign blk_addr = i_reg + chip8_bus_pkg::addr_t'(cnt);
  assign rd_y_idx = ir.nib.y;
  assign alu_n = ir.nib.n;
  assign push_addr = pc + chip8_bus_pkg::INSTR_BYTES;
  assign timer_load_value = rd_x_data;
  assign flag_data = chip8_bus_pkg::data_t'(alu_flag);
  assign flag_wr_en = (state == S_EXEC) && (ir.nib.op == chip8_isa_pkg::OP_ALU) && alu_flag_en;

  always_comb begin
    case (cnt)
      4'd0: bcd_digit = rd_x_data / 8'd100;
      4'd1: bcd_digit = (rd_x_data / 8'd10) % 8'd10;
      default: bcd_digit = rd_x_data % 8'd10;
    endcase
  end

  // Fx55 walks V0..Vx, Bnnn needs V0
  always_comb begin
    rd_x_idx = ir.nib.x;
    if (state == S_STORE) begin
      rd_x_idx = cnt;
    end else if (ir.nib.op == chip8_isa_pkg::OP_JP_V0) begin
      rd_x_idx = '0;
    end
  end

  // no request while reset is held
  always_comb begin
    mem_req_valid = !reset;
    mem_req_write = 1'b0;
    mem_addr = pc;
    mem_wdata = rd_x_data;
    case (state)
      S_FETCH_HI: ;
      S_FETCH_LO: mem_addr = pc + 12'd1;
      S_BCD: begin
        mem_req_write = 1'b1;
        mem_addr = blk_addr;
        mem_wdata = bcd_digit;
      end
      S_STORE: begin
        mem_req_write = 1'b1;
        mem_addr = blk_addr;
      end
      S_LOAD: mem_addr = blk_addr;
      default: mem_req_valid = 1'b0;
    endcase
  end

  // single-cycle execute effects
  always_comb begin
    wr_en = 1'b0;
    wr_idx = ir.nib.x;
    wr_data = ir.imm.kk;
    stack_push = 1'b0;
    stack_pop = 1'b0;
    timer_load = 1'b0;
    skip = 1'b0;
    if (state == S_EXEC) begin
      case (ir.nib.op)
        chip8_isa_pkg::OP_SYS: stack_pop = is_ret;
        chip8_isa_pkg::OP_CALL: stack_push = 1'b1;
        chip8_isa_pkg::OP_SE_IMM: skip = (rd_x_data == ir.imm.kk);
        chip8_isa_pkg::OP_SNE_IMM: skip = (rd_x_data != ir.imm.kk);
        chip8_isa_pkg::OP_SE_REG: skip = (ir.nib.n == 4'h0) && (rd_x_data == rd_y_data);
        chip8_isa_pkg::OP_SNE_REG: skip = (ir.nib.n == 4'h0) && (rd_x_data != rd_y_data);
        chip8_isa_pkg::OP_LD_IMM: wr_en = 1'b1;
        chip8_isa_pkg::OP_ADD_IMM: begin
          wr_en = 1'b1;
          wr_data = rd_x_data + ir.imm.kk;
        end
        // undefined 8xyN comes back from the ALU as Vx unchanged
        chip8_isa_pkg::OP_ALU: begin
          wr_en = 1'b1;
          wr_data = alu_result;
        end
        chip8_isa_pkg::OP_MISC: begin
          if (ir.imm.kk == chip8_isa_pkg::MISC_GET_DT) begin
            wr_en = 1'b1;
            wr_data = timer_value;
          end
          timer_load = (ir.imm.kk == chip8_isa_pkg::MISC_SET_DT);
        end
        default: ;
      endcase
    end else if (state == S_LOAD_WAIT && mem_rsp_valid) begin
      wr_en = 1'b1;
      wr_idx = cnt;
      wr_data = mem_rdata;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= S_FETCH_HI;
      pc <= chip8_bus_pkg::PROGRAM_START;
      i_reg <= '0;
      cnt <= '0;
    end else begin
      case (state)
        S_FETCH_HI: if (mem_req_ready) state <= S_FETCH_HI_WAIT;
        S_FETCH_LO: if (mem_req_ready) state <= S_FETCH_LO_WAIT;
        S_LOAD: if (mem_req_ready) state <= S_LOAD_WAIT;
        S_FETCH_HI_WAIT: begin
          if (mem_rsp_valid) begin
            ir[15:8] <= mem_rdata;
            state <= S_FETCH_LO;
          end
        end
        S_FETCH_LO_WAIT: begin
          if (mem_rsp_valid) begin
            ir[7:0] <= mem_rdata;
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          // pc moves here once, block moves below never touch it
          state <= S_FETCH_HI;
          cnt <= '0;
          pc <= pc + chip8_bus_pkg::INSTR_BYTES + (skip ? chip8_bus_pkg::INSTR_BYTES : 12'd0);
          case (ir.nib.op)
            chip8_isa_pkg::OP_SYS: if (is_ret) pc <= stack_top;
            chip8_isa_pkg::OP_JP: pc <= ir.addr.nnn;
            chip8_isa_pkg::OP_CALL: pc <= ir.addr.nnn;
            chip8_isa_pkg::OP_JP_V0: pc <= ir.addr.nnn + chip8_bus_pkg::addr_t'(rd_x_data);
            chip8_isa_pkg::OP_LD_I: i_reg <= ir.addr.nnn;
            chip8_isa_pkg::OP_MISC: begin
              case (ir.imm.kk)
                chip8_isa_pkg::MISC_ADD_I: i_reg <= i_reg + chip8_bus_pkg::addr_t'(rd_x_data);
                chip8_isa_pkg::MISC_BCD: state <= S_BCD;
                chip8_isa_pkg::MISC_STORE: state <= S_STORE;
                chip8_isa_pkg::MISC_LOAD: state <= S_LOAD;
                default: ;
              endcase
            end
            default: ;
          endcase
        end
        S_BCD: begin
          if (mem_req_ready) begin
            cnt <= cnt + 4'd1;
            if (cnt == 4'd2) state <= S_FETCH_HI;
          end
        end
        S_STORE: begin
          if (mem_req_ready) begin
            cnt <= cnt + 4'd1;
            if (cnt == ir.nib.x) state <= S_FETCH_HI;
          end
        end
        S_LOAD_WAIT: begin
          if (mem_rsp_valid) begin
            cnt <= cnt + 4'd1;
            state <= (cnt == ir.nib.x) ? S_FETCH_HI : S_LOAD;
          end
        end
        default: state <= S_FETCH_HI;
      endcase
    end
  end

  // a stalled request holds until the memory takes it
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
      && $stable(mem_addr) && $stable(mem_wdata));

  // responses only while a read is outstanding
  a_rsp_outstanding: assert property (@(posedge clk) disable iff (reset)
    mem_rsp_valid |-> state inside {S_FETCH_HI_WAIT, S_FETCH_LO_WAIT, S_LOAD_WAIT});

endmodule

`default_nettype wire

// File: hdl/chip8_cpu.sv
// CHIP-8 CPU core, fetches and executes over a byte-wide valid/ready memory port
// TICK_DIV sets the delay timer rate and STACK_DEPTH the call depth
`timescale 1ns/1ns
`default_nettype none

module chip8_cpu #(
  parameter int TICK_DIV = 1666667,
  parameter int STACK_DEPTH = 16
) (
  input wire clk,
  input wire reset,
  input wire mem_req_ready,
  input wire mem_rsp_valid,
  input wire chip8_bus_pkg::data_t mem_rdata,
  output logic mem_req_valid,
  output logic mem_req_write,
  output chip8_bus_pkg::addr_t mem_addr,
  output chip8_bus_pkg::data_t mem_wdata
);

  chip8_isa_pkg::reg_idx_t rd_x_idx;
  chip8_isa_pkg::reg_idx_t rd_y_idx;
  chip8_isa_pkg::reg_idx_t wr_idx;
  chip8_bus_pkg::data_t rd_x_data;
  chip8_bus_pkg::data_t rd_y_data;
  chip8_bus_pkg::data_t wr_data;
  chip8_bus_pkg::data_t flag_data;
  chip8_bus_pkg::data_t alu_result;
  chip8_bus_pkg::data_t timer_value;
  chip8_bus_pkg::data_t timer_load_value;
  chip8_bus_pkg::addr_t stack_top;
  chip8_bus_pkg::addr_t push_addr;
  logic [3:0] alu_n;
  logic wr_en;
  logic flag_wr_en;
  logic alu_flag;
  logic alu_flag_en;
  logic stack_push;
  logic stack_pop;
  logic timer_load;

  chip8_control chip8_control_inst (
    .clk, .reset,
    .mem_req_ready, .mem_rsp_valid, .mem_rdata,
    .rd_x_data, .rd_y_data,
    .alu_result, .alu_flag, .alu_flag_en,
    .stack_top, .timer_value,
    .mem_req_valid, .mem_req_write, .mem_addr, .mem_wdata,
    .rd_x_idx, .rd_y_idx,
    .wr_en, .wr_idx, .wr_data, .flag_wr_en, .flag_data,
    .alu_n, .stack_push, .stack_pop, .push_addr,
    .timer_load, .timer_load_value
  );

  chip8_regfile chip8_regfile_inst (
    .clk, .reset, .rd_x_idx, .rd_y_idx,
    .wr_en, .wr_idx, .wr_data, .flag_wr_en, .flag_data,
    .rd_x_data, .rd_y_data
  );

  chip8_alu chip8_alu_inst (
    .a(rd_x_data), .b(rd_y_data), .n(alu_n),
    .result(alu_result), .flag(alu_flag), .flag_en(alu_flag_en)
  );

  chip8_call_stack #(.STACK_DEPTH(STACK_DEPTH)) chip8_call_stack_inst (
    .clk, .reset, .push(stack_push), .pop(stack_pop), .push_addr, .top(stack_top)
  );

  chip8_delay_timer #(.TICK_DIV(TICK_DIV)) chip8_delay_timer_inst (
    .clk, .reset, .load(timer_load), .load_value(timer_load_value), .value(timer_value)
  );

endmodule

`default_nettype wire

// File: dv/chip8_tb_memory.sv
// byte-wide test memory for the CHIP-8 CPU testbench, preloaded with the test program
// ready stalls at random and reads answer after 1 to 3 cycles
`timescale 1ns/1ns
`default_nettype none

module chip8_tb_memory (
  input wire clk,
  input wire reset,
  input wire req_valid,
  input wire req_write,
  input wire chip8_bus_pkg::addr_t addr,
  input wire chip8_bus_pkg::data_t wdata,
  output logic req_ready,
  output logic rsp_valid,
  output chip8_bus_pkg::data_t rdata
);

  // test program from 200, ends on the self-jump at 28C
  localparam logic [15:0] PROGRAM [71] = '{
    16'h61C8, 16'h6264, 16'h8010, 16'h8024, 16'h83F0, 16'h8420, 16'h8415, 16'h85F0,
    16'h8620, 16'h7601, 16'h8666, 16'h87F0, 16'h8810, 16'h888E, 16'h89F0, 16'h8A10,
    16'h8A21, 16'h8B10, 16'h8B22, 16'h8C10, 16'h8C23, 16'h8D20, 16'h8D17, 16'h8EF0,
    16'hA310, 16'hFE55, 16'h63FE, 16'hA300, 16'hF333, 16'h6004, 16'h6607, 16'h6707,
    16'h6A00, 16'h22C0, 16'h6991, 16'h3607, 16'h6AE1, 16'h61A1, 16'h3608, 16'h62A2,
    16'h4608, 16'h6AE2, 16'h63A3, 16'h4607, 16'h64A4, 16'h5670, 16'h6AE3, 16'h6BA5,
    16'h9670, 16'h6CA6, 16'hB266, 16'h6AE4, 16'h6AE5, 16'h68B0, 16'hA320, 16'hFC55,
    16'hA1F0, 16'h6010, 16'hF01E, 16'hF365, 16'hA330, 16'hF355, 16'h6503, 16'hF515,
    16'hF407, 16'h3400, 16'h1280, 16'h8040, 16'hA340, 16'hF055, 16'h128C
  };

  chip8_bus_pkg::data_t mem [4096];
  chip8_bus_pkg::addr_t rd_addr;
  logic pending;
  int lat_left;
  int extra_wait;

  initial begin
    for (int a = 0; a < 4096; a++) begin
      mem[a] <= 8'(a ^ (a >> 4));
    end
    for (int w = 0; w < $size(PROGRAM); w++) begin
      mem[chip8_bus_pkg::PROGRAM_START + 2 * w] <= PROGRAM[w][15:8];
      mem[chip8_bus_pkg::PROGRAM_START + 2 * w + 1] <= PROGRAM[w][7:0];
    end
    // subroutine: V5 = C5, return
    mem[12'h2C0] <= 8'h65;
    mem[12'h2C1] <= 8'hC5;
    mem[12'h2C2] <= 8'h00;
    mem[12'h2C3] <= 8'hEE;
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      req_ready <= 1'b0;
      rsp_valid <= 1'b0;
      rdata <= '0;
      rd_addr <= '0;
      pending <= 1'b0;
      lat_left <= 0;
    end else begin
      rsp_valid <= 1'b0;
      req_ready <= ($urandom_range(3, 0) != 0);
      if (pending) begin
        if (lat_left == 1) begin
          rsp_valid <= 1'b1;
          rdata <= mem[rd_addr];
          pending <= 1'b0;
        end else begin
          lat_left <= lat_left - 1;
        end
      end
      if (req_valid && req_ready) begin
        if (req_write) begin
          mem[addr] <= wdata;
        end else begin
          extra_wait = $urandom_range(2, 0);
          // zero extra wait answers in the very next cycle
          if (extra_wait == 0) begin
            rsp_valid <= 1'b1;
            rdata <= mem[addr];
          end else begin
            pending <= 1'b1;
            lat_left <= extra_wait;
            rd_addr <= addr;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/chip8_cpu_tb.sv
// CHIP-8 CPU testbench, runs the fixed program and checks every memory write in order
// against values worked out from the instruction rules
`timescale 1ns/1ns
`default_nettype none

module chip8_cpu_tb;

  localparam int WRITE_COUNT = 36;
  localparam int SECTION_LIMIT = 3000;

  // {address, byte} of each write in program order
  localparam logic [19:0] EXPECTED [WRITE_COUNT] = '{
    // V0..VE after the ALU ops, stored at 310
    20'h310_2C, 20'h311_C8, 20'h312_64, 20'h313_01, 20'h314_9C, 20'h315_00, 20'h316_32,
    20'h317_01, 20'h318_90, 20'h319_01, 20'h31A_EC, 20'h31B_40, 20'h31C_AC, 20'h31D_64,
    20'h31E_01,
    // 254 as BCD
    20'h300_02, 20'h301_05, 20'h302_04,
    // flow markers V0..VC, VA stays 0 unless a wrong path ran
    20'h320_04, 20'h321_A1, 20'h322_A2, 20'h323_A3, 20'h324_A4, 20'h325_C5, 20'h326_07,
    20'h327_07, 20'h328_B0, 20'h329_91, 20'h32A_00, 20'h32B_A5, 20'h32C_A6,
    // first two program words copied through V0..V3
    20'h330_61, 20'h331_C8, 20'h332_62, 20'h333_64,
    // delay timer read back after it ran out
    20'h340_00
  };

  logic clk;
  logic reset;
  logic mem_req_valid;
  logic mem_req_write;
  logic mem_req_ready;
  logic mem_rsp_valid;
  chip8_bus_pkg::addr_t mem_addr;
  chip8_bus_pkg::data_t mem_wdata;
  chip8_bus_pkg::data_t mem_rdata;
  int write_idx = 0;
  logic first_seen = 1'b0;

  chip8_cpu #(.TICK_DIV(20)) chip8_cpu_inst (
    .clk, .reset, .mem_req_ready, .mem_rsp_valid, .mem_rdata,
    .mem_req_valid, .mem_req_write, .mem_addr, .mem_wdata
  );

  chip8_tb_memory chip8_tb_memory_inst (
    .clk, .reset,
    .req_valid(mem_req_valid), .req_write(mem_req_write), .addr(mem_addr), .wdata(mem_wdata),
    .req_ready(mem_req_ready), .rsp_valid(mem_rsp_valid), .rdata(mem_rdata)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "testbench stopped at the first error");
  endtask

  task automatic describe_failure(input string what);
    $display("%s", what);
    abort_run();
  endtask

  task automatic show_mismatch(input string test, input logic [19:0] exp,
                               input logic [19:0] act);
    $display("ERROR %s: expected %h, actual %h", test, exp, act);
    abort_run();
  endtask

  function automatic string section_name(input int idx);
    if (idx < 15) return "alu_flags";
    if (idx < 18) return "bcd";
    if (idx < 31) return "flow_control";
    if (idx < 35) return "block_load_i";
    return "delay_timer_and_backpressure";
  endfunction

  task automatic wait_for_writes(input int target, input string test);
    int cycles;
    cycles = 0;
    while (write_idx < target && cycles < SECTION_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (write_idx < target) describe_failure({test, ": timed out waiting for memory writes"});
  endtask

  // transfers are logged on the edge where valid and ready are both high
  always @(posedge clk) begin
    if (!reset && mem_req_valid && mem_req_ready) begin
      if (!first_seen) begin
        first_seen <= 1'b1;
        a_first_fetch: assert (!mem_req_write && mem_addr == chip8_bus_pkg::PROGRAM_START)
          else show_mismatch("reset_fetch", 20'(chip8_bus_pkg::PROGRAM_START),
                             {7'd0, mem_req_write, mem_addr});
      end
      if (mem_req_write) begin
        a_write_in_table: assert (write_idx < WRITE_COUNT)
          else describe_failure("memory write after the last expected one");
        a_write_value: assert ({mem_addr, mem_wdata} == EXPECTED[write_idx])
          else show_mismatch(section_name(write_idx), EXPECTED[write_idx],
                             {mem_addr, mem_wdata});
        write_idx <= write_idx + 1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) reset |-> !mem_req_valid)
    else describe_failure("reset_fetch: mem_req_valid was high during reset");

  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write)
      && $stable(mem_addr) && $stable(mem_wdata))
    else describe_failure("delay_timer_and_backpressure: stalled request changed before transfer");

  initial begin
    void'($urandom(50256));
    clk = 1'b0;
    reset <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait_for_writes(15, "alu_flags");
    wait_for_writes(18, "bcd");
    wait_for_writes(31, "flow_control");
    wait_for_writes(35, "block_load_i");
    wait_for_writes(36, "delay_timer_and_backpressure");
    // program now spins on its self-jump, any further write is caught above
    repeat (50) @(posedge clk);
    if (write_idx == WRITE_COUNT && first_seen) begin
      $display("Simulation passed");
      $finish;
    end else begin
      describe_failure("run ended without all expected memory traffic");
    end
  end

endmodule

`default_nettype wire

// File: chip8_cpu.f
hdl/chip8_bus_pkg.sv
hdl/chip8_isa_pkg.sv
hdl/chip8_alu.sv
hdl/chip8_regfile.sv
hdl/chip8_call_stack.sv
hdl/chip8_delay_timer.sv
hdl/chip8_control.sv
hdl/chip8_cpu.sv
dv/chip8_tb_memory.sv
dv/chip8_cpu_tb.sv

// File: Makefile
# Verilator build and run of the CHIP-8 CPU testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f chip8_cpu.f \
		--top-module chip8_cpu_tb -Mdir obj_dir
	./obj_dir/Vchip8_cpu_tb

clean:
	rm -rf obj_dir
